//--- include/avgp_params.svh
`ifndef AVGP_PARAMS_SVH
`define AVGP_PARAMS_SVH

// Bits per pixel sample
`define AVGP_DATA_WIDTH 8

// Real image size in pixel positions
`define AVGP_IMG_W 8
`define AVGP_IMG_H 6

// Channels interleaved inside one pixel position
`define AVGP_CHANNELS 2

// Counter widths over the padded scan grid
`define AVGP_CH_BITS  $clog2(`AVGP_CHANNELS)
`define AVGP_COL_BITS $clog2(`AVGP_IMG_W + 1)
`define AVGP_ROW_BITS $clog2(`AVGP_IMG_H + 1)

// One padded row of all channels
`define AVGP_LB_DEPTH ((`AVGP_IMG_W + 1) * `AVGP_CHANNELS)

`endif

//--- src/avgp_pkg.sv
`include "avgp_params.svh"

package avgp_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data types

	// One unsigned pixel sample
	typedef logic [`AVGP_DATA_WIDTH-1:0] pxl_t;

	// Window sum with four guard bits for nine terms
	typedef logic [`AVGP_DATA_WIDTH+3:0] sum_t;

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	// Scan phases of one frame
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		RUN     = 3'd1,
		PAD_COL = 3'd2,
		PAD_ROW = 3'd3,
		FLUSH   = 3'd4
	} ctrl_state_t;

endpackage

//--- src/avgp_ctrl.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module avgp_ctrl import avgp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic valid_in,
	input  pxl_t pxl_in,
	input  logic last_in_row,
	input  logic last_in_frame,
	input  logic col_is_last_real,
	input  logic core_valid_out,
	output logic scan_step,
	output pxl_t scan_pxl,
	output logic busy,
	output logic frame_done
);

	localparam int ROW_BITS = `AVGP_ROW_BITS;
	localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(`AVGP_IMG_H - 1);

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	// Real rows completed in this frame
	logic [ROW_BITS-1:0] rows_done;
	// Cycles spent draining
	logic [1:0] flush_cnt;

	logic accept;
	logic last_real_row;
	logic flush_end;

	// Source pixels only taken outside padding
	assign accept        = valid_in && ((state == IDLE) || (state == RUN));
	assign last_real_row = (rows_done == LAST_ROW);
	// Third drain cycle, last result on the core output
	assign flush_end     = (state == FLUSH) && (flush_cnt == 2'd2);

	//////////////////////////////////////////////////////////////////////
	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE, RUN: begin
				if (accept) begin
					state_nxt = col_is_last_real ? PAD_COL : RUN;
				end
			end
			PAD_COL: begin
				// Bottom pad row follows the last real row
				if (last_in_row) begin
					state_nxt = last_real_row ? PAD_ROW : RUN;
				end
			end
			PAD_ROW: begin
				if (last_in_frame) begin
					state_nxt = FLUSH;
				end
			end
			FLUSH: begin
				if (flush_end) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			rows_done  <= '0;
			flush_cnt  <= '0;
			frame_done <= 1'b0;
		end else begin
			state      <= state_nxt;
			frame_done <= flush_end && core_valid_out;
			if ((state == PAD_COL) && last_in_row) begin
				rows_done <= rows_done + 1'b1;
			end else if (state == FLUSH) begin
				rows_done <= '0;
			end
			// Drain timer
			if (state == FLUSH) begin
				flush_cnt <= flush_cnt + 1'b1;
			end else begin
				flush_cnt <= '0;
			end
		end
	end

	// Padding steps run every cycle with a zero pixel
	assign busy      = (state == PAD_COL) || (state == PAD_ROW) || (state == FLUSH);
	assign scan_step = accept || (state == PAD_COL) || (state == PAD_ROW);
	assign scan_pxl  = accept ? pxl_in : '0;

	// Source holds off through padding and drain
	assert property (@(posedge clk) disable iff (reset) busy |-> !valid_in)
		else $error("valid_in asserted while busy");

	assert property (@(posedge clk) disable iff (reset)
		state inside {IDLE, RUN, PAD_COL, PAD_ROW, FLUSH})
		else $error("illegal control state %0d", state);

endmodule

//--- src/scan_counter.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module scan_counter import avgp_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      scan_step,
	output logic [`AVGP_CH_BITS-1:0]  ch,
	output logic [`AVGP_COL_BITS-1:0] col,
	output logic [`AVGP_ROW_BITS-1:0] row,
	output logic                      col_is_last_real,
	output logic                      last_in_row,
	output logic                      last_in_frame
);

	localparam int CH_BITS  = `AVGP_CH_BITS;
	localparam int COL_BITS = `AVGP_COL_BITS;
	localparam int ROW_BITS = `AVGP_ROW_BITS;

	localparam logic [CH_BITS-1:0]  CH_LAST  = CH_BITS'(`AVGP_CHANNELS - 1);
	localparam logic [COL_BITS-1:0] COL_REAL = COL_BITS'(`AVGP_IMG_W - 1);
	localparam logic [COL_BITS-1:0] COL_PAD  = COL_BITS'(`AVGP_IMG_W);
	localparam logic [ROW_BITS-1:0] ROW_PAD  = ROW_BITS'(`AVGP_IMG_H);

	logic ch_last;

	// Final channel of a position
	assign ch_last = (ch == CH_LAST);

	// Last real column done, padding column next
	assign col_is_last_real = ch_last && (col == COL_REAL);
	assign last_in_row      = ch_last && (col == COL_PAD);
	assign last_in_frame    = last_in_row && (row == ROW_PAD);

	// Channel inner, then column, then row
	always_ff @(posedge clk) begin
		if (reset) begin
			ch  <= '0;
			col <= '0;
			row <= '0;
		end else if (scan_step) begin
			if (last_in_frame) begin
				ch  <= '0;
				col <= '0;
				row <= '0;
			end else if (ch_last) begin
				ch <= '0;
				if (col == COL_PAD) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end else begin
				ch <= ch + 1'b1;
			end
		end
	end

	// Padded grid bound
	assert property (@(posedge clk) disable iff (reset) col <= COL_PAD)
		else $error("col %0d past padded width", col);

endmodule

//--- src/window_buffer.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module window_buffer import avgp_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      scan_step,
	input  pxl_t                      scan_pxl,
	input  logic [`AVGP_CH_BITS-1:0]  ch,
	input  logic [`AVGP_COL_BITS-1:0] col,
	input  logic [`AVGP_ROW_BITS-1:0] row,
	output pxl_t                      tap_00,
	output pxl_t                      tap_01,
	output pxl_t                      tap_02,
	output pxl_t                      tap_10,
	output pxl_t                      tap_11,
	output pxl_t                      tap_12,
	output pxl_t                      tap_20,
	output pxl_t                      tap_21,
	output pxl_t                      tap_22,
	output logic                      win_valid
);

	localparam int CH_BITS  = `AVGP_CH_BITS;
	localparam int COL_BITS = `AVGP_COL_BITS;
	localparam int ROW_BITS = `AVGP_ROW_BITS;
	localparam int LB_AW    = $clog2(`AVGP_LB_DEPTH);

	localparam logic [COL_BITS-1:0] COL_ONE = COL_BITS'(1);
	localparam logic [ROW_BITS-1:0] ROW_ONE = ROW_BITS'(1);

	// Line buffers, one row and two rows above
	pxl_t line_a [`AVGP_LB_DEPTH];
	pxl_t line_b [`AVGP_LB_DEPTH];

	// Window per channel, [row][column], column 2 newest
	pxl_t win [`AVGP_CHANNELS][3][3];

	logic [LB_AW-1:0] lb_addr;
	pxl_t             up_1;
	pxl_t             up_2;

	logic [CH_BITS-1:0] ch_q;
	logic               mask_top;
	logic               mask_left;

	//////////////////////////////////////////////////////////////////////
	// Line buffers

	// Slot of this column and channel
	assign lb_addr = LB_AW'(col) * LB_AW'(`AVGP_CHANNELS) + LB_AW'(ch);

	assign up_1 = line_a[lb_addr];
	assign up_2 = line_b[lb_addr];

	// Older row moves down a buffer
	always_ff @(posedge clk) begin
		if (scan_step) begin
			line_a[lb_addr] <= scan_pxl;
			line_b[lb_addr] <= up_1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 3x3 window

	// Only the current channel shifts
	always_ff @(posedge clk) begin
		if (scan_step) begin
			for (int r = 0; r < 3; r++) begin
				win[ch][r][0] <= win[ch][r][1];
				win[ch][r][1] <= win[ch][r][2];
			end
			// New column, top to bottom
			win[ch][0][2] <= up_2;
			win[ch][1][2] <= up_1;
			win[ch][2][2] <= scan_pxl;
		end
	end

	// Centre sits one row and one column back
	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else begin
			win_valid <= scan_step && (row != '0) && (col != '0);
		end
	end

	// Window edge flags for zero padding
	always_ff @(posedge clk) begin
		if (scan_step) begin
			ch_q      <= ch;
			mask_top  <= (row == ROW_ONE);
			mask_left <= (col == COL_ONE);
		end
	end

	// Top row and left column fall outside the image at the edges
	assign tap_00 = (mask_top || mask_left) ? '0 : win[ch_q][0][0];
	assign tap_01 = mask_top ? '0 : win[ch_q][0][1];
	assign tap_02 = mask_top ? '0 : win[ch_q][0][2];
	assign tap_10 = mask_left ? '0 : win[ch_q][1][0];
	assign tap_11 = win[ch_q][1][1];
	assign tap_12 = win[ch_q][1][2];
	assign tap_20 = mask_left ? '0 : win[ch_q][2][0];
	assign tap_21 = win[ch_q][2][1];
	assign tap_22 = win[ch_q][2][2];

endmodule

//--- src/avgp_core.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module avgp_core import avgp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic win_valid,
	input  pxl_t tap_00,
	input  pxl_t tap_01,
	input  pxl_t tap_02,
	input  pxl_t tap_10,
	input  pxl_t tap_11,
	input  pxl_t tap_12,
	input  pxl_t tap_20,
	input  pxl_t tap_21,
	input  pxl_t tap_22,
	output pxl_t pxl_out,
	output logic valid_out
);

	// Half of nine, rounds up
	localparam sum_t ROUND   = sum_t'(4);
	localparam sum_t DIVISOR = sum_t'(9);
	localparam sum_t PXL_MAX = sum_t'({`AVGP_DATA_WIDTH{1'b1}});

	sum_t row_sum_0;
	sum_t row_sum_1;
	sum_t row_sum_2;
	logic stage1_valid;
	sum_t total;
	sum_t quot;

	// Stage one, row sums
	always_ff @(posedge clk) begin
		if (win_valid) begin
			row_sum_0 <= sum_t'(tap_00) + sum_t'(tap_01) + sum_t'(tap_02);
			row_sum_1 <= sum_t'(tap_10) + sum_t'(tap_11) + sum_t'(tap_12);
			row_sum_2 <= sum_t'(tap_20) + sum_t'(tap_21) + sum_t'(tap_22);
		end
	end

	// Stage two, total and rounded divide
	assign total = row_sum_0 + row_sum_1 + row_sum_2 + ROUND;
	assign quot  = total / DIVISOR;

	always_ff @(posedge clk) begin
		if (stage1_valid) begin
			pxl_out <= pxl_t'(quot);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage1_valid <= 1'b0;
			valid_out    <= 1'b0;
		end else begin
			stage1_valid <= win_valid;
			valid_out    <= stage1_valid;
		end
	end

	// Average of pixels fits a pixel
	assert property (@(posedge clk) disable iff (reset) stage1_valid |-> quot <= PXL_MAX)
		else $error("quotient %0d exceeds pixel range", quot);

endmodule

//--- src/avgp_top.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module avgp_top import avgp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic valid_in,
	input  pxl_t pxl_in,
	output pxl_t pxl_out,
	output logic valid_out,
	output logic busy,
	output logic frame_done
);

	// Scan stream
	logic scan_step;
	pxl_t scan_pxl;

	// Grid position
	logic [`AVGP_CH_BITS-1:0]  ch;
	logic [`AVGP_COL_BITS-1:0] col;
	logic [`AVGP_ROW_BITS-1:0] row;
	logic                      col_is_last_real;
	logic                      last_in_row;
	logic                      last_in_frame;

	// Window taps
	logic win_valid;
	pxl_t tap_00;
	pxl_t tap_01;
	pxl_t tap_02;
	pxl_t tap_10;
	pxl_t tap_11;
	pxl_t tap_12;
	pxl_t tap_20;
	pxl_t tap_21;
	pxl_t tap_22;

	logic core_valid;

	assign valid_out = core_valid;

	//////////////////////////////////////////////////////////////////////
	// Control and position
	avgp_ctrl u_ctrl (
		.clk              (clk),
		.reset            (reset),
		.valid_in         (valid_in),
		.pxl_in           (pxl_in),
		.last_in_row      (last_in_row),
		.last_in_frame    (last_in_frame),
		.col_is_last_real (col_is_last_real),
		.core_valid_out   (core_valid),
		.scan_step        (scan_step),
		.scan_pxl         (scan_pxl),
		.busy             (busy),
		.frame_done       (frame_done)
	);

	scan_counter u_scan_counter (
		.clk              (clk),
		.reset            (reset),
		.scan_step        (scan_step),
		.ch               (ch),
		.col              (col),
		.row              (row),
		.col_is_last_real (col_is_last_real),
		.last_in_row      (last_in_row),
		.last_in_frame    (last_in_frame)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	window_buffer u_window_buffer (
		.clk       (clk),
		.reset     (reset),
		.scan_step (scan_step),
		.scan_pxl  (scan_pxl),
		.ch        (ch),
		.col       (col),
		.row       (row),
		.tap_00    (tap_00),
		.tap_01    (tap_01),
		.tap_02    (tap_02),
		.tap_10    (tap_10),
		.tap_11    (tap_11),
		.tap_12    (tap_12),
		.tap_20    (tap_20),
		.tap_21    (tap_21),
		.tap_22    (tap_22),
		.win_valid (win_valid)
	);

	avgp_core u_core (
		.clk       (clk),
		.reset     (reset),
		.win_valid (win_valid),
		.tap_00    (tap_00),
		.tap_01    (tap_01),
		.tap_02    (tap_02),
		.tap_10    (tap_10),
		.tap_11    (tap_11),
		.tap_12    (tap_12),
		.tap_20    (tap_20),
		.tap_21    (tap_21),
		.tap_22    (tap_22),
		.pxl_out   (pxl_out),
		.valid_out (core_valid)
	);

endmodule

//--- tests/avgp_checker.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module avgp_checker import avgp_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic valid_in,
	input  pxl_t pxl_in,
	input  pxl_t pxl_out,
	input  logic valid_out,
	input  logic busy,
	input  logic frame_done,
	input  logic quiet_check,
	input  logic const_check,
	input  pxl_t exp_corner,
	input  pxl_t exp_edge,
	input  pxl_t exp_inner,
	input  logic end_check,
	input  int   expected_frames,
	output int   error_count,
	output int   check_count,
	output int   out_total,
	output int   frame_count
);

	localparam int W        = `AVGP_IMG_W;
	localparam int H        = `AVGP_IMG_H;
	localparam int CH       = `AVGP_CHANNELS;
	localparam int FRAME_PX = W * H * CH;

	// Accepted inputs of the current frame
	pxl_t frame_mem [H][W][CH];

	int   in_idx;
	int   out_idx;
	int   busy_rises;
	logic busy_q;
	logic valid_out_q;

	initial begin
		error_count = 0;
		check_count = 0;
		out_total   = 0;
		frame_count = 0;
	end

	task automatic report_mismatch(input string name, input int expected,
		input logic [31:0] actual);
		error_count++;
		$display("Fail time=%0t signal=%s expected=%0d actual=%0d",
			$time, name, expected, actual);
	endtask

	task automatic report_problem(input string what);
		error_count++;
		$display("Error at time %0t: %s", $time, what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Nine-value window, zeros outside, rounded half up
	function automatic int ref_average(input int r, input int c, input int k);
		int sum;
		sum = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				if ((r + dr >= 0) && (r + dr < H) && (c + dc >= 0) && (c + dc < W)) begin
					sum += int'(frame_mem[r + dr][c + dc][k]);
				end
			end
		end
		return (sum + 4) / 9;
	endfunction

	// Corner, edge or interior value of a flat frame
	function automatic pxl_t flat_value(input int r, input int c);
		logic row_edge;
		logic col_edge;
		row_edge = (r == 0) || (r == H - 1);
		col_edge = (c == 0) || (c == W - 1);
		if (row_edge && col_edge) begin
			return exp_corner;
		end
		if (row_edge || col_edge) begin
			return exp_edge;
		end
		return exp_inner;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Monitor
	always @(posedge clk) begin : watch
		int   r;
		int   c;
		int   k;
		pxl_t exp_px;
		if (reset) begin
			in_idx      = 0;
			out_idx     = 0;
			busy_rises  = 0;
			busy_q      = 1'b0;
			valid_out_q = 1'b0;
		end else begin
			// Nothing may move while idle
			if (quiet_check) begin
				if (valid_out !== 1'b0) report_mismatch("valid_out", 0, valid_out);
				if (busy !== 1'b0) report_mismatch("busy", 0, busy);
				if (frame_done !== 1'b0) report_mismatch("frame_done", 0, frame_done);
			end
			if (valid_in && busy) begin
				report_problem("valid_in driven while busy is high");
			end
			// Output stream, raster then channel order
			if (valid_out === 1'b1) begin
				out_total++;
				if (out_idx >= FRAME_PX) begin
					report_problem("valid_out beyond the pixel count of one frame");
				end else begin
					r      = out_idx / (W * CH);
					c      = (out_idx / CH) % W;
					k      = out_idx % CH;
					exp_px = pxl_t'(ref_average(r, c, k));
					check_count++;
					if (pxl_out !== exp_px) report_mismatch("pxl_out", exp_px, pxl_out);
					if (const_check) begin
						check_count++;
						if (pxl_out !== flat_value(r, c)) begin
							report_mismatch("pxl_out", flat_value(r, c), pxl_out);
						end
					end
					out_idx++;
				end
			end else if (valid_out !== 1'b0) begin
				report_problem("valid_out is unknown");
			end
			if (busy && !busy_q) begin
				busy_rises++;
			end
			// Frame end bookkeeping
			if (frame_done === 1'b1) begin
				frame_count++;
				check_count++;
				if (out_idx != FRAME_PX) report_mismatch("frame output count", FRAME_PX, out_idx);
				if (in_idx != FRAME_PX) report_mismatch("frame input count", FRAME_PX, in_idx);
				if (busy_rises != H) report_mismatch("busy rises per frame", H, busy_rises);
				if (!valid_out_q) begin
					report_problem("frame_done did not follow the last valid_out");
				end
				in_idx     = 0;
				out_idx    = 0;
				busy_rises = 0;
			end
			// Inputs taken by the DUT
			if ((valid_in === 1'b1) && (busy === 1'b0)) begin
				if (in_idx >= FRAME_PX) begin
					report_problem("more inputs than one frame before frame_done");
				end else begin
					frame_mem[in_idx / (W * CH)][(in_idx / CH) % W][in_idx % CH] = pxl_in;
					in_idx++;
				end
			end
			if (end_check) begin
				check_count++;
				if (frame_count != expected_frames) begin
					report_mismatch("frame_done count", expected_frames, frame_count);
				end
				if ((in_idx != 0) || (out_idx != 0)) report_problem("a frame was left unfinished");
			end
			busy_q      = busy;
			valid_out_q = valid_out;
		end
	end

endmodule

//--- tests/tb_avgp.sv
`timescale 1ns/1ps
`include "avgp_params.svh"

module tb_avgp import avgp_pkg::*; ();

	localparam int W          = `AVGP_IMG_W;
	localparam int H          = `AVGP_IMG_H;
	localparam int CH         = `AVGP_CHANNELS;
	localparam int NUM_FRAMES = 7;
	localparam int SEED_INIT  = 88024;
	localparam int WAIT_LIMIT = 200;

	localparam int KIND_CONST   = 0;
	localparam int KIND_RAMP    = 1;
	localparam int KIND_RANDOM  = 2;
	localparam int KIND_CHECKER = 3;

	//////////////////////////////////////////////////////////////////////
	// Stimulus table with one row per frame
	// Flat frames carry corner, edge and interior results
	int tbl_kind   [NUM_FRAMES] = '{KIND_CONST, KIND_RAMP, KIND_RANDOM, KIND_RANDOM,
		KIND_CHECKER, KIND_CONST, KIND_CONST};
	int tbl_value  [NUM_FRAMES] = '{255, 0, 0, 0, 0, 9, 255};
	int tbl_gap    [NUM_FRAMES] = '{0, 0, 0, 40, 25, 0, 50};
	int tbl_corner [NUM_FRAMES] = '{113, 0, 0, 0, 0, 4, 113};
	int tbl_edge   [NUM_FRAMES] = '{170, 0, 0, 0, 0, 6, 170};
	int tbl_inner  [NUM_FRAMES] = '{255, 0, 0, 0, 0, 9, 255};

	logic clk;
	logic reset;
	logic valid_in;
	pxl_t pxl_in;
	pxl_t pxl_out;
	logic valid_out;
	logic busy;
	logic frame_done;

	// Checker controls and counts
	logic quiet_check;
	logic const_check;
	logic end_check;
	pxl_t exp_corner;
	pxl_t exp_edge;
	pxl_t exp_inner;
	int   error_count;
	int   check_count;
	int   out_total;
	int   frame_count;

	// Set when a bounded wait ran out
	bit timed_out;

	// Gap stream and data stream
	integer seed;
	integer data_seed;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	avgp_top u_avgp_top (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.busy       (busy),
		.frame_done (frame_done)
	);

	avgp_checker u_checker (
		.clk             (clk),
		.reset           (reset),
		.valid_in        (valid_in),
		.pxl_in          (pxl_in),
		.pxl_out         (pxl_out),
		.valid_out       (valid_out),
		.busy            (busy),
		.frame_done      (frame_done),
		.quiet_check     (quiet_check),
		.const_check     (const_check),
		.exp_corner      (exp_corner),
		.exp_edge        (exp_edge),
		.exp_inner       (exp_inner),
		.end_check       (end_check),
		.expected_frames (NUM_FRAMES),
		.error_count     (error_count),
		.check_count     (check_count),
		.out_total       (out_total),
		.frame_count     (frame_count)
	);

	task automatic finish_run();
		$display("Summary: checks %0d, errors %0d, outputs %0d, frames %0d, timeouts %0d",
			check_count, error_count, out_total, frame_count, timed_out);
		if (timed_out || (error_count != 0)) begin
			$display("*** FAILED ***");
		end else begin
			$display("*** PASSED ***");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bounded waits sampled on the falling edge
	task automatic wait_busy_high();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((busy !== 1'b1) && (n < WAIT_LIMIT));
		if (busy !== 1'b1) begin
			$display("Timeout: busy never rose after the last pixel of a row");
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_busy_low();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((busy !== 1'b0) && (n < WAIT_LIMIT));
		if (busy !== 1'b0) begin
			$display("Timeout: busy stayed high through the padding column");
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_frame_done();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((frame_done !== 1'b1) && (n < WAIT_LIMIT));
		if (frame_done !== 1'b1) begin
			$display("Timeout: frame_done never pulsed at the end of a frame");
			timed_out = 1'b1;
		end
	endtask

	// One frame from table row f
	task automatic apply_frame(input int f);
		int   idle;
		pxl_t px;
		data_seed = SEED_INIT;
		const_check <= (tbl_kind[f] == KIND_CONST);
		exp_corner  <= pxl_t'(tbl_corner[f]);
		exp_edge    <= pxl_t'(tbl_edge[f]);
		exp_inner   <= pxl_t'(tbl_inner[f]);
		for (int r = 0; r < H; r++) begin
			for (int c = 0; c < W; c++) begin
				for (int k = 0; k < CH; k++) begin
					// Random idle cycles ahead of a pixel
					if ((tbl_gap[f] > 0) && (($unsigned($random(seed)) % 100) < tbl_gap[f])) begin
						idle = 1 + ($unsigned($random(seed)) % 3);
						repeat (idle) begin
							@(posedge clk);
							valid_in <= 1'b0;
						end
					end
					case (tbl_kind[f])
						KIND_CONST:  px = pxl_t'(tbl_value[f]);
						KIND_RAMP:   px = pxl_t'(tbl_value[f] + (r * W + c) * 4 + k * 2);
						KIND_RANDOM: px = pxl_t'($random(data_seed));
						default:     px = (((r + c + k) % 2) == 1) ? '1 : '0;
					endcase
					@(posedge clk);
					valid_in <= 1'b1;
					pxl_in   <= px;
				end
			end
			// Hold off through the padding column
			@(posedge clk);
			valid_in <= 1'b0;
			wait_busy_high();
			if (timed_out) begin
				return;
			end
			if (r == H - 1) begin
				wait_frame_done();
			end else begin
				wait_busy_low();
			end
			if (timed_out) begin
				return;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		reset       = 1'b1;
		valid_in    = 1'b0;
		pxl_in      = '0;
		quiet_check = 1'b0;
		const_check = 1'b0;
		end_check   = 1'b0;
		exp_corner  = '0;
		exp_edge    = '0;
		exp_inner   = '0;
		timed_out   = 1'b0;
		seed        = SEED_INIT;
		data_seed   = SEED_INIT;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// Quiet period with no input
		@(posedge clk);
		quiet_check <= 1'b1;
		repeat (20) @(posedge clk);
		quiet_check <= 1'b0;
		for (int f = 0; (f < NUM_FRAMES) && !timed_out; f++) begin
			$display("Frame %0d: kind %0d, gap %0d%%", f, tbl_kind[f], tbl_gap[f]);
			apply_frame(f);
		end
		// Nothing more after the last frame
		@(posedge clk);
		quiet_check <= 1'b1;
		repeat (10) @(posedge clk);
		end_check <= 1'b1;
		@(posedge clk);
		end_check <= 1'b0;
		@(posedge clk);
		finish_run();
	end

endmodule

//--- build.f
+incdir+include
src/avgp_pkg.sv
src/avgp_ctrl.sv
src/scan_counter.sv
src/window_buffer.sv
src/avgp_core.sv
src/avgp_top.sv
tests/avgp_checker.sv
tests/tb_avgp.sv

//--- Makefile
# Verilator flow for the average-pooling block

VERILATOR  ?= verilator
TOP        ?= tb_avgp
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
FLAGS      ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --timing --assert

SOURCES := $(wildcard src/*.sv tests/*.sv include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
